/* rtl/axi_cfg_pkg.sv */
`default_nettype none

package axi_cfg_pkg;

    localparam int axi_data_width = 64;
    localparam int axi_strb_width = axi_data_width / 8;
    localparam int axi_lane_width = axi_data_width / 2;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    // two 32-bit lanes, picked by address bit 2
    typedef struct packed {
        logic [axi_lane_width-1:0] hi;
        logic [axi_lane_width-1:0] lo;
    } axi_lanes_t;

    typedef union packed {
        logic [axi_data_width-1:0] word;
        axi_lanes_t                lane;
    } axi_data_t;

endpackage

`default_nettype wire

/* rtl/plic_pkg.sv */
`default_nettype none

package plic_pkg;

    // priority and threshold width
    localparam int prio_width = 3;

    // upper bound for num_sources, one enable word
    localparam int max_sources = 32;

    localparam int reg_width = 32;

    // register map, byte offsets
    // priority of source i sits at off_priority_base + 4*i
    localparam logic [15:0] off_priority_base = 16'h0000;
    localparam logic [15:0] off_pending       = 16'h1000;
    localparam logic [15:0] off_enable        = 16'h2000;
    localparam logic [15:0] off_threshold     = 16'h3000;
    localparam logic [15:0] off_claim         = 16'h3004;

    // source 0 is reserved: never pending, never claimed,
    // its priority and enable bit read as zero

endpackage

`default_nettype wire

/* rtl/plic_reg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface plic_reg_if #(
    parameter int addr_width = 16
) ();
    import plic_pkg::*;

    logic [addr_width-1:0]  waddr;
    logic [reg_width-1:0]   wdata;
    logic [reg_width/8-1:0] wstrb;
    logic                   wen;
    logic [addr_width-1:0]  raddr;
    logic                   ren;
    logic [reg_width-1:0]   rdata;

    modport bus (output waddr, wdata, wstrb, wen, raddr, ren, input rdata);

    modport regs (input waddr, wdata, wstrb, wen, raddr, ren, output rdata);

endinterface

`default_nettype wire

/* rtl/axi_lite_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave #(
    parameter int addr_width = 16
) (
    input  wire                                    S_AXI_ACLK,
    input  wire                                    S_AXI_ARESETN,
    input  wire  [addr_width-1:0]                  awaddr,
    input  wire                                    awvalid,
    output logic                                   awready,
    input  wire  axi_cfg_pkg::axi_data_t           wdata,
    input  wire  [axi_cfg_pkg::axi_strb_width-1:0] wstrb,
    input  wire                                    wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  wire                                    bready,
    input  wire  [addr_width-1:0]                  araddr,
    input  wire                                    arvalid,
    output logic                                   arready,
    output axi_cfg_pkg::axi_data_t                 rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  wire                                    rready,
    plic_reg_if.bus                                reg_port
);
    import axi_cfg_pkg::*;
    import plic_pkg::*;

    // shared by both fsms, read side never uses st_data
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;
    localparam logic [1:0] st_resp = 2'd3;

    logic [1:0]            wr_state;
    logic [1:0]            rd_state;
    logic [addr_width-1:0] aw_addr_q;
    logic [addr_width-1:0] wr_addr;
    logic                  wr_hi;
    logic [reg_width-1:0]  rd_word;
    logic                  rd_hi;

    assign awready = (wr_state == st_addr);
    // W only with an address on the bus or latched
    assign wready  = (wr_state == st_addr && awvalid) || (wr_state == st_data);
    assign bvalid  = (wr_state == st_resp);
    assign bresp   = axi_resp_okay;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_state <= st_idle;
        end else begin
            case (wr_state)
                st_idle: wr_state <= st_addr;
                st_addr: begin
                    if (awvalid) begin
                        wr_state <= wvalid ? st_resp : st_data;
                    end
                end
                st_data: begin
                    if (wvalid) begin
                        wr_state <= st_resp;
                    end
                end
                st_resp: begin
                    if (bready) begin
                        wr_state <= st_addr;
                    end
                end
                default: wr_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
    end

    assign wr_addr = (wr_state == st_data) ? aw_addr_q : awaddr;
    assign wr_hi   = wr_addr[2];

    // bit 2 stays in the address, it tells the two registers of a 64-bit word apart
    assign reg_port.waddr = wr_addr;
    assign reg_port.wdata = wr_hi ? wdata.lane.hi : wdata.lane.lo;
    assign reg_port.wstrb = wr_hi ? wstrb[axi_strb_width-1 -: reg_width/8]
                                  : wstrb[reg_width/8-1:0];
    assign reg_port.wen   = wvalid && wready;

    assign arready = (rd_state == st_addr);
    assign rvalid  = (rd_state == st_resp);
    assign rresp   = axi_resp_okay;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_state <= st_idle;
        end else begin
            case (rd_state)
                st_idle: rd_state <= st_addr;
                st_addr: begin
                    if (arvalid) begin
                        rd_state <= st_resp;
                    end
                end
                st_resp: begin
                    if (rready) begin
                        rd_state <= st_addr;
                    end
                end
                default: rd_state <= st_idle;
            endcase
        end
    end

    assign reg_port.raddr = araddr;
    assign reg_port.ren   = arvalid && arready;

    // core read data is combinational, capture at the AR handshake
    always_ff @(posedge S_AXI_ACLK) begin
        if (reg_port.ren) begin
            rd_word <= reg_port.rdata;
            rd_hi   <= araddr[2];
        end
    end

    always_comb begin
        rdata = '0;
        if (rd_hi) begin
            rdata.lane.hi = rd_word;
        end else begin
            rdata.lane.lo = rd_word;
        end
    end

    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid);

    a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* rtl/plic_gateway.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_gateway #(
    parameter int num_sources = 8
) (
    input  wire                    S_AXI_ACLK,
    input  wire                    S_AXI_ARESETN,
    input  wire [num_sources-1:0]  sources,
    input  wire [num_sources-1:0]  claim_onehot,
    input  wire [num_sources-1:0]  complete_onehot,
    output logic [num_sources-1:0] pending
);

    // source 0 reserved
    localparam logic [num_sources-1:0] src_mask = ~num_sources'(1);

    logic [num_sources-1:0] in_service;
    logic [num_sources-1:0] new_req;

    // level sources, a new request only once the previous one is done
    assign new_req = sources & ~pending & ~in_service & src_mask;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            pending    <= '0;
            in_service <= '0;
        end else begin
            pending    <= (pending | new_req) & ~claim_onehot;
            // claim moves pending -> in service
            in_service <= (in_service | (claim_onehot & pending)) & ~complete_onehot;
        end
    end

endmodule

`default_nettype wire

/* rtl/plic_core.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_core #(
    parameter int addr_width  = 16,
    parameter int num_sources = 8
) (
    input  wire                   S_AXI_ACLK,
    input  wire                   S_AXI_ARESETN,
    input  wire [num_sources-1:0] sources,
    plic_reg_if.regs              reg_port,
    output logic                  irq_valid
);
    import plic_pkg::*;

    localparam int id_width = $clog2(num_sources);
    localparam logic [num_sources-1:0] src_mask = ~num_sources'(1);

    localparam logic [addr_width-1:0] a_prio_base = addr_width'(off_priority_base);
    localparam logic [addr_width-1:0] a_pending   = addr_width'(off_pending);
    localparam logic [addr_width-1:0] a_enable    = addr_width'(off_enable);
    localparam logic [addr_width-1:0] a_threshold = addr_width'(off_threshold);
    localparam logic [addr_width-1:0] a_claim     = addr_width'(off_claim);

    logic [prio_width-1:0]  prio [num_sources];
    logic [num_sources-1:0] enable;
    logic [prio_width-1:0]  threshold;
    logic [num_sources-1:0] pending;
    logic [num_sources-1:0] claim_onehot;
    logic [num_sources-1:0] complete_onehot;
    logic [addr_width-1:0]  w_prio_off;
    logic [addr_width-1:0]  r_prio_off;
    logic                   w_prio_hit;
    logic                   r_prio_hit;
    logic [id_width-1:0]    w_prio_idx;
    logic [id_width-1:0]    r_prio_idx;
    logic [reg_width-1:0]   en_merged;
    logic [id_width-1:0]    best_id;
    logic [prio_width-1:0]  best_prio;
    logic                   claim_rd;
    logic                   cpl_wr;

    initial assert (num_sources > 1 && num_sources <= max_sources)
        else $fatal(1, "num_sources out of range");

    assign w_prio_off = reg_port.waddr - a_prio_base;
    assign r_prio_off = reg_port.raddr - a_prio_base;
    assign w_prio_hit = (w_prio_off[1:0] == 2'b00) && ((w_prio_off >> 2) < addr_width'(num_sources));
    assign r_prio_hit = (r_prio_off[1:0] == 2'b00) && ((r_prio_off >> 2) < addr_width'(num_sources));
    assign w_prio_idx = w_prio_off[2 +: id_width];
    assign r_prio_idx = r_prio_off[2 +: id_width];

    // byte-strobe merge for the enable word
    always_comb begin
        en_merged = reg_width'(enable);
        for (int b = 0; b < reg_width / 8; b++) begin
            if (reg_port.wstrb[b]) begin
                en_merged[8*b +: 8] = reg_port.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            for (int i = 0; i < num_sources; i++) begin
                prio[i] <= '0;
            end
            enable    <= '0;
            threshold <= '0;
        end else if (reg_port.wen) begin
            // priority and threshold live in byte 0
            if (w_prio_hit && w_prio_idx != '0 && reg_port.wstrb[0]) begin
                prio[w_prio_idx] <= reg_port.wdata[prio_width-1:0];
            end
            if (reg_port.waddr == a_enable) begin
                enable <= en_merged[num_sources-1:0] & src_mask;
            end
            if (reg_port.waddr == a_threshold && reg_port.wstrb[0]) begin
                threshold <= reg_port.wdata[prio_width-1:0];
            end
        end
    end

    // strict compare keeps the lower id on ties, and must beat the threshold
    always_comb begin
        best_id   = '0;
        best_prio = threshold;
        for (int i = 1; i < num_sources; i++) begin
            if (pending[i] && enable[i] && prio[i] > best_prio) begin
                best_id   = id_width'(i);
                best_prio = prio[i];
            end
        end
    end

    assign claim_rd = reg_port.ren && (reg_port.raddr == a_claim);
    assign cpl_wr   = reg_port.wen && (reg_port.waddr == a_claim)
                      && (reg_port.wdata < reg_width'(num_sources));

    assign claim_onehot    = claim_rd ? (num_sources'(1) << best_id) & src_mask : '0;
    assign complete_onehot = cpl_wr ? num_sources'(1) << reg_port.wdata[id_width-1:0] : '0;

    plic_gateway #(
        .num_sources(num_sources)
    ) u_gateway (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .sources        (sources),
        .claim_onehot   (claim_onehot),
        .complete_onehot(complete_onehot),
        .pending        (pending)
    );

    always_comb begin
        reg_port.rdata = '0;
        if (r_prio_hit) begin
            reg_port.rdata = reg_width'(prio[r_prio_idx]);
        end else if (reg_port.raddr == a_pending) begin
            reg_port.rdata = reg_width'(pending);
        end else if (reg_port.raddr == a_enable) begin
            reg_port.rdata = reg_width'(enable);
        end else if (reg_port.raddr == a_threshold) begin
            reg_port.rdata = reg_width'(threshold);
        end else if (reg_port.raddr == a_claim) begin
            reg_port.rdata = reg_width'(best_id);
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            irq_valid <= 1'b0;
        end else begin
            irq_valid <= (best_id != '0);
        end
    end

    a_claim_id_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        claim_rd |-> reg_port.rdata < reg_width'(num_sources));

endmodule

`default_nettype wire

/* rtl/plic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_top #(
    parameter int addr_width  = 16,
    parameter int num_sources = 8
) (
    input  wire                                   S_AXI_ACLK,
    input  wire                                   S_AXI_ARESETN,
    input  wire [addr_width-1:0]                  S_AXI_AWADDR,
    input  wire [2:0]                             S_AXI_AWPROT,
    input  wire                                   S_AXI_AWVALID,
    output wire                                   S_AXI_AWREADY,
    input  wire [axi_cfg_pkg::axi_data_width-1:0] S_AXI_WDATA,
    input  wire [axi_cfg_pkg::axi_strb_width-1:0] S_AXI_WSTRB,
    input  wire                                   S_AXI_WVALID,
    output wire                                   S_AXI_WREADY,
    output wire [1:0]                             S_AXI_BRESP,
    output wire                                   S_AXI_BVALID,
    input  wire                                   S_AXI_BREADY,
    input  wire [addr_width-1:0]                  S_AXI_ARADDR,
    input  wire [2:0]                             S_AXI_ARPROT,
    input  wire                                   S_AXI_ARVALID,
    output wire                                   S_AXI_ARREADY,
    output wire [axi_cfg_pkg::axi_data_width-1:0] S_AXI_RDATA,
    output wire [1:0]                             S_AXI_RRESP,
    output wire                                   S_AXI_RVALID,
    input  wire                                   S_AXI_RREADY,
    input  wire [num_sources-1:0]                 irq_sources,
    output wire                                   irq_valid
);

    plic_reg_if #(.addr_width(addr_width)) reg_bus ();

    // AWPROT and ARPROT are accepted but carry no meaning here
    axi_lite_slave #(
        .addr_width(addr_width)
    ) u_slave (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .awaddr       (S_AXI_AWADDR),
        .awvalid      (S_AXI_AWVALID),
        .awready      (S_AXI_AWREADY),
        .wdata        (S_AXI_WDATA),
        .wstrb        (S_AXI_WSTRB),
        .wvalid       (S_AXI_WVALID),
        .wready       (S_AXI_WREADY),
        .bresp        (S_AXI_BRESP),
        .bvalid       (S_AXI_BVALID),
        .bready       (S_AXI_BREADY),
        .araddr       (S_AXI_ARADDR),
        .arvalid      (S_AXI_ARVALID),
        .arready      (S_AXI_ARREADY),
        .rdata        (S_AXI_RDATA),
        .rresp        (S_AXI_RRESP),
        .rvalid       (S_AXI_RVALID),
        .rready       (S_AXI_RREADY),
        .reg_port     (reg_bus.bus)
    );

    plic_core #(
        .addr_width (addr_width),
        .num_sources(num_sources)
    ) u_core (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .sources      (irq_sources),
        .reg_port     (reg_bus.regs),
        .irq_valid    (irq_valid)
    );

endmodule

`default_nettype wire

/* testbench/tb_plic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_plic_top;
    import axi_cfg_pkg::*;
    import plic_pkg::*;

    localparam int nsrc       = 8;
    localparam int wait_limit = 50;
    localparam int poll_limit = 20;

    logic            S_AXI_ACLK;
    logic            S_AXI_ARESETN;
    logic [15:0]     S_AXI_AWADDR;
    logic [2:0]      S_AXI_AWPROT;
    logic            S_AXI_AWVALID;
    wire             S_AXI_AWREADY;
    logic [63:0]     S_AXI_WDATA;
    logic [7:0]      S_AXI_WSTRB;
    logic            S_AXI_WVALID;
    wire             S_AXI_WREADY;
    wire  [1:0]      S_AXI_BRESP;
    wire             S_AXI_BVALID;
    logic            S_AXI_BREADY;
    logic [15:0]     S_AXI_ARADDR;
    logic [2:0]      S_AXI_ARPROT;
    logic            S_AXI_ARVALID;
    wire             S_AXI_ARREADY;
    wire  [63:0]     S_AXI_RDATA;
    wire  [1:0]      S_AXI_RRESP;
    wire             S_AXI_RVALID;
    logic            S_AXI_RREADY;
    logic [nsrc-1:0] irq_sources;
    wire             irq_valid;

    // reference model state
    logic [prio_width-1:0] m_prio [nsrc];
    logic [nsrc-1:0]       m_enable;
    logic [nsrc-1:0]       m_pending;
    logic [nsrc-1:0]       m_in_service;
    logic [prio_width-1:0] m_threshold;

    logic [31:0] lfsr_state;
    logic [63:0] exp_q [$];
    logic        chk_q [$];

    plic_top #(
        .addr_width (16),
        .num_sources(nsrc)
    ) u_dut (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // galois lfsr, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA300_0000 : lfsr_state >> 1;
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] place_lane(input logic [15:0] addr, input logic [31:0] word);
        return addr[2] ? {word, 32'h0} : {32'h0, word};
    endfunction

    // highest priority above threshold, lowest id on ties
    function automatic void ref_eval(output logic [2:0] id, output logic [nsrc-1:0] pend,
                                     output logic irq);
        id   = '0;
        pend = m_pending;
        for (int p = 7; p > int'(m_threshold); p--) begin
            if (id == '0) begin
                for (int i = nsrc - 1; i >= 1; i--) begin
                    if (pend[i] && m_enable[i] && int'(m_prio[i]) == p) begin
                        id = 3'(i);
                    end
                end
            end
        end
        irq = (id != '0);
    endfunction

    function automatic logic [31:0] ref_reg(input logic [15:0] addr);
        logic [2:0]      id;
        logic [nsrc-1:0] pend;
        logic            irq;
        logic [31:0]     word;
        ref_eval(id, pend, irq);
        word = '0;
        if (addr < 16'(4 * nsrc)) begin
            word = 32'(m_prio[addr[4:2]]);
        end else if (addr == off_pending) begin
            word = 32'(pend);
        end else if (addr == off_enable) begin
            word = 32'(m_enable);
        end else if (addr == off_threshold) begin
            word = 32'(m_threshold);
        end else if (addr == off_claim) begin
            word = 32'(id);
        end
        return word;
    endfunction

    // level sources latch into pending unless in service
    function automatic void settle_model();
        m_pending = (m_pending | (irq_sources & ~m_in_service)) & ~nsrc'(1);
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [63:0] data,
                                        input logic [7:0] strb);
        logic [31:0] lane;
        logic [3:0]  nib;
        logic [31:0] en_word;
        lane    = addr[2] ? data[63:32] : data[31:0];
        nib     = addr[2] ? strb[7:4] : strb[3:0];
        en_word = 32'(m_enable);
        if (addr < 16'(4 * nsrc)) begin
            if (addr[4:2] != 3'd0 && nib[0]) begin
                m_prio[addr[4:2]] = lane[prio_width-1:0];
            end
        end else if (addr == off_enable) begin
            for (int b = 0; b < 4; b++) begin
                if (nib[b]) begin
                    en_word[8*b +: 8] = lane[8*b +: 8];
                end
            end
            m_enable = en_word[nsrc-1:0] & ~nsrc'(1);
        end else if (addr == off_threshold) begin
            if (nib[0]) begin
                m_threshold = lane[prio_width-1:0];
            end
        end else if (addr == off_claim && lane < 32'(nsrc)) begin
            m_in_service[lane[2:0]] = 1'b0;
        end
        settle_model();
    endfunction

    function automatic void model_claim();
        logic [2:0]      id;
        logic [nsrc-1:0] pend;
        logic            irq;
        ref_eval(id, pend, irq);
        if (id != '0) begin
            m_pending[id]    = 1'b0;
            m_in_service[id] = 1'b1;
        end
    endfunction

    function automatic logic [15:0] pick_addr();
        int sel;
        sel = int'(rand_bits(4) % 64'd11);
        case (sel)
            8:       return off_pending;
            9:       return off_enable;
            10:      return off_threshold;
            default: return 16'(4 * sel);
        endcase
    endfunction

    function automatic logic signal_level(input string name);
        case (name)
            "S_AXI_AWREADY": return S_AXI_AWREADY;
            "S_AXI_WREADY":  return S_AXI_WREADY;
            "S_AXI_BVALID":  return S_AXI_BVALID;
            "S_AXI_ARREADY": return S_AXI_ARREADY;
            default:         return S_AXI_RVALID;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic wait_for(input string name);
        int t;
        t = 0;
        while (!signal_level(name)) begin
            @(negedge S_AXI_ACLK);
            t++;
            if (t > wait_limit) begin
                $display("timeout waiting for %s to go high", name);
                stop_on_failure();
            end
        end
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input logic split, input int hold);
        @(negedge S_AXI_ACLK);
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_WVALID  = !split;
        wait_for("S_AXI_AWREADY");
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        // address alone, data follows
        if (split) begin
            S_AXI_WVALID = 1'b1;
            wait_for("S_AXI_WREADY");
            @(negedge S_AXI_ACLK);
        end
        S_AXI_WVALID = 1'b0;
        wait_for("S_AXI_BVALID");
        check_value("S_AXI_BRESP", 64'(S_AXI_BRESP), 64'(axi_resp_okay));
        for (int i = 0; i < hold; i++) begin
            @(negedge S_AXI_ACLK);
            check_value("S_AXI_BVALID", 64'(S_AXI_BVALID), 64'd1);
            check_value("S_AXI_AWREADY", 64'(S_AXI_AWREADY), 64'd0);
            check_value("S_AXI_WREADY", 64'(S_AXI_WREADY), 64'd0);
        end
        S_AXI_BREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, input logic do_check,
                            input logic [63:0] want, input int hold,
                            output logic [63:0] data);
        @(negedge S_AXI_ACLK);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        wait_for("S_AXI_ARREADY");
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        wait_for("S_AXI_RVALID");
        data = S_AXI_RDATA;
        check_value("S_AXI_RRESP", 64'(S_AXI_RRESP), 64'(axi_resp_okay));
        for (int i = 0; i < hold; i++) begin
            @(negedge S_AXI_ACLK);
            check_value("S_AXI_RVALID", 64'(S_AXI_RVALID), 64'd1);
            check_value("S_AXI_RDATA", S_AXI_RDATA, data);
            check_value("S_AXI_ARREADY", 64'(S_AXI_ARREADY), 64'd0);
        end
        exp_q.push_back(want);
        chk_q.push_back(do_check);
        S_AXI_RREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input int hold);
        axi_write(addr, data, strb, 1'(rand_bits(1)), hold);
        model_write(addr, data, strb);
    endtask

    task automatic reg_read_check(input logic [15:0] addr, input int hold);
        logic [63:0] got;
        axi_read(addr, 1'b1, place_lane(addr, ref_reg(addr)), hold, got);
        if (addr == off_claim) begin
            model_claim();
        end
    endtask

    task automatic poll_pending();
        logic [63:0] want;
        logic [63:0] got;
        int          t;
        want = place_lane(off_pending, 32'(m_pending));
        t    = 0;
        axi_read(off_pending, 1'b0, '0, 0, got);
        while (got !== want && t < poll_limit) begin
            axi_read(off_pending, 1'b0, '0, 0, got);
            t++;
        end
        check_value("S_AXI_RDATA", got, want);
    endtask

    task automatic wait_irq(input logic want);
        int t;
        t = 0;
        while (irq_valid !== want && t < poll_limit) begin
            @(negedge S_AXI_ACLK);
            t++;
        end
        check_value("irq_valid", 64'(irq_valid), 64'(want));
    endtask

    // read data check at the R handshake
    always @(posedge S_AXI_ACLK) begin
        logic [63:0] exp_word;
        logic        do_check;
        if (S_AXI_RVALID && S_AXI_RREADY) begin
            if (exp_q.size() == 0) begin
                $display("read response arrived with no read outstanding");
                stop_on_failure();
            end else begin
                exp_word = exp_q.pop_front();
                do_check = chk_q.pop_front();
                if (do_check) begin
                    check_value("S_AXI_RDATA", S_AXI_RDATA, exp_word);
                end
            end
        end
    end

    initial begin
        logic [15:0]     addr;
        logic [2:0]      id;
        logic [nsrc-1:0] pend;
        logic            irq;
        logic [nsrc-1:0] claimed;
        int              n;

        lfsr_state    = 32'h8441_e5a3;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWPROT  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARPROT  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        irq_sources   = '0;
        for (int i = 0; i < nsrc; i++) begin
            m_prio[i] = '0;
        end
        m_enable     = '0;
        m_pending    = '0;
        m_in_service = '0;
        m_threshold  = '0;
        repeat (5) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;

        check_value("S_AXI_BVALID", 64'(S_AXI_BVALID), 64'd0);
        check_value("S_AXI_RVALID", 64'(S_AXI_RVALID), 64'd0);
        check_value("irq_valid", 64'(irq_valid), 64'd0);
        @(negedge S_AXI_ACLK);
        check_value("S_AXI_AWREADY", 64'(S_AXI_AWREADY), 64'd1);
        for (int i = 0; i < nsrc; i++) begin
            reg_read_check(16'(4 * i), 0);
        end
        reg_read_check(off_enable, 0);
        reg_read_check(off_threshold, 0);

        // read-back through both lanes
        repeat (40) begin
            addr = pick_addr();
            reg_write(addr, rand_bits(64), 8'(rand_bits(8)), 0);
            reg_read_check(addr, 0);
        end

        @(negedge S_AXI_ACLK);
        irq_sources = 8'(rand_bits(8));
        settle_model();
        poll_pending();

        repeat (4) begin
            for (int i = 1; i < nsrc; i++) begin
                reg_write(16'(4 * i), place_lane(16'(4 * i), 32'(rand_bits(3))), 8'hff, 0);
            end
            reg_write(off_enable, place_lane(off_enable, 32'(rand_bits(8))), 8'hff, 0);
            reg_write(off_threshold, place_lane(off_threshold, 32'(rand_bits(2))), 8'hff, 0);
            @(negedge S_AXI_ACLK);
            irq_sources = 8'(rand_bits(8));
            settle_model();
            poll_pending();
            claimed = '0;
            n       = 0;
            ref_eval(id, pend, irq);
            while (id != '0 && n < nsrc) begin
                wait_irq(1'b1);
                reg_read_check(off_claim, 0);
                claimed[id] = 1'b1;
                reg_read_check(off_pending, 0);
                ref_eval(id, pend, irq);
                n++;
            end
            // nothing eligible, claim gives id 0
            wait_irq(1'b0);
            reg_read_check(off_claim, 0);
            for (int i = 1; i < nsrc; i++) begin
                if (claimed[i]) begin
                    reg_write(off_claim, place_lane(off_claim, 32'(i)), 8'hf0, 0);
                    reg_read_check(off_pending, 0);
                end
            end
            ref_eval(id, pend, irq);
            wait_irq(irq);
        end

        // responses held back by the master
        repeat (12) begin
            addr = pick_addr();
            reg_write(addr, rand_bits(64), 8'(rand_bits(8)), 1 + int'(rand_bits(4)));
            reg_read_check(addr, 1 + int'(rand_bits(4)));
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/axi_cfg_pkg.sv
rtl/plic_pkg.sv
rtl/plic_reg_if.sv
rtl/axi_lite_slave.sv
rtl/plic_gateway.sv
rtl/plic_core.sv
rtl/plic_top.sv
testbench/tb_plic_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_plic_top -f sim.f

# the simulation passes only if its output holds the pass line
run: compile
	@out="$$(./obj_dir/Vtb_plic_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
